// File: src/fuse_params.svh
// Fuse controller sizing macros
// Shared by the package and every block of the fuse controller
`ifndef FUSE_PARAMS_SVH
`define FUSE_PARAMS_SVH

// Number of fuse partitions, the last one holds the life-cycle data
`define FUSE_NUM_PART 4

// Fuse words held in each partition
`define FUSE_PART_WORDS 8

// Width of one fuse word in bits
`define FUSE_WORD_W 32

// Entries in the command queue
// This is also the number of credits the issue stage starts with
`define FUSE_QUEUE_DEPTH 4

// Upper bound in cycles from escalation to the terminal engine state
`define FUSE_ESC_LATENCY 10

`endif

// File: src/fusePkg.sv
// Fuse controller types
// Life-cycle encodings, command opcodes, result codes, engine states
// and the command record that moves between the pipeline stages
`include "fuse_params.svh"

package fusePkg;

  // Encoded life-cycle state as delivered by the life-cycle controller
  // Codes are spread apart so that a single flipped bit lands on an unknown value
  typedef enum logic [7:0] {
    Raw           = 8'h3c,
    TestUnlocked0 = 8'h5a,
    TestLocked0   = 8'h69,
    Dev           = 8'h96,
    Prod          = 8'ha5,
    ProdEnd       = 8'hc3,
    Rma           = 8'he1
  } lcStateE;

  // Decoded phase in life-cycle order so that phases can be compared
  typedef enum logic [2:0] {
    DecRaw,
    DecTestUnlocked0,
    DecTestLocked0,
    DecDev,
    DecProd,
    DecProdEnd,
    DecRma,
    DecScrap
  } decLcStateE;

  // Phase after which each partition becomes write-locked
  // The life-cycle partition sits at the top and is never passed
  localparam decLcStateE partPhaseTable [`FUSE_NUM_PART] = '{
    DecTestUnlocked0,
    DecDev,
    DecProd,
    DecScrap
  };

  typedef enum logic {
    OpRead,
    OpProgram
  } fuseOpE;

  // Result of a command as reported to the host
  typedef enum logic [1:0] {
    NoErr,
    AccessErr,
    BlankErr,
    FsmStateError
  } fuseErrE;

  typedef enum logic [1:0] {
    IdleSt,
    AccessSt,
    RespSt,
    ErrorSt
  } daiStateE;

  // One queued command, preErr carries a verdict already reached at issue
  typedef struct packed {
    fuseOpE                                op;
    logic [$clog2(`FUSE_NUM_PART)-1:0]   part;
    logic [$clog2(`FUSE_PART_WORDS)-1:0] addr;
    logic [`FUSE_WORD_W-1:0]             wdata;
    fuseErrE                               preErr;
  } fuseCmdT;

endpackage

// File: src/fuseCmdIntf.sv
// Credit-based command link between two fuse controller stages
// The source pushes commands and the sink hands credits back
interface fuseCmdIntf
  import fusePkg::*;
();

  // Single-cycle strobe that qualifies cmd
  logic    push;
  fuseCmdT cmd;

  // One-cycle pulse for every entry the sink frees
  logic    creditReturn;

  // Sending side owns the credit counter
  modport src (
    output push,
    output cmd,
    input  creditReturn
  );

  // Receiving side
  modport dst (
    input  push,
    input  cmd,
    output creditReturn
  );

endinterface

// File: src/lcPartitionLock.sv
// Life-cycle decode and partition write locks
// Turns the encoded life-cycle state into per-partition write locks
// and holds escalation until the next reset
`include "fuse_params.svh"

module lcPartitionLock
  import fusePkg::*;
(
  input  logic                      clk,
  input  logic                      rstN,
  input  lcStateE                   lcState,
  input  logic                      escalateEn,
  output logic [`FUSE_NUM_PART-1:0] writeLock,
  output logic                      escalated
);

  decLcStateE decLcState;

  // Anything outside the known codes is treated as a scrapped part
  function automatic decLcStateE decodeLcState(input lcStateE state);
    case (state)
      Raw:           return DecRaw;
      TestUnlocked0: return DecTestUnlocked0;
      TestLocked0:   return DecTestLocked0;
      Dev:           return DecDev;
      Prod:          return DecProd;
      ProdEnd:       return DecProdEnd;
      Rma:           return DecRma;
      default:       return DecScrap;
    endcase
  endfunction

  assign decLcState = decodeLcState(lcState);

  // A partition locks as soon as the device has moved past its phase
  // The life-cycle partition is never locked here
  always_ff @(posedge clk) begin
    if (!rstN) begin
      writeLock <= '0;
    end else begin
      for (int i = 0; i < `FUSE_NUM_PART - 1; i++) begin
        writeLock[i] <= decLcState > partPhaseTable[i];
      end
      writeLock[`FUSE_NUM_PART-1] <= 1'b0;
    end
  end

  // Escalation is sticky and only reset clears it
  always_ff @(posedge clk) begin
    if (!rstN) begin
      escalated <= 1'b0;
    end else if (escalateEn) begin
      escalated <= 1'b1;
    end
  end

endmodule

// File: src/fuseCmdIssue.sv
// Fuse command issue stage
// Accepts host requests while credits remain, decides lock and escalation
// errors up front and pushes the command towards the queue
`include "fuse_params.svh"

module fuseCmdIssue
  import fusePkg::*;
(
  input  logic                                clk,
  input  logic                                rstN,
  input  logic                                reqValid,
  output logic                                reqReady,
  input  fuseOpE                              reqOp,
  input  logic [$clog2(`FUSE_NUM_PART)-1:0]   reqPart,
  input  logic [$clog2(`FUSE_PART_WORDS)-1:0] reqAddr,
  input  logic [`FUSE_WORD_W-1:0]             reqWdata,
  input  logic [`FUSE_NUM_PART-1:0]           writeLock,
  input  logic                                escalated,
  fuseCmdIntf.src                             cmdOut
);

  localparam int CreditW = $clog2(`FUSE_QUEUE_DEPTH + 1);

  logic [CreditW-1:0] credits;
  logic               accept;
  fuseErrE            preErr;

  // Ready only while the queue is known to have a free entry
  assign reqReady = credits != '0;
  assign accept   = reqValid && reqReady;

  // This is the single point where write locks are applied
  // Escalation wins over a lock violation
  always_comb begin
    if (escalated) begin
      preErr = FsmStateError;
    end else if (reqOp == OpProgram && writeLock[reqPart]) begin
      preErr = AccessErr;
    end else begin
      preErr = NoErr;
    end
  end

  // Spend a credit per accepted request and regain one per returned pulse
  // Both can happen in the same cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      credits <= CreditW'(`FUSE_QUEUE_DEPTH);
    end else begin
      credits <= credits - CreditW'(accept) + CreditW'(cmdOut.creditReturn);
    end
  end

  // Push strobe lands one cycle after the handshake
  always_ff @(posedge clk) begin
    if (!rstN) begin
      cmdOut.push <= 1'b0;
    end else begin
      cmdOut.push <= accept;
    end
  end

  // Command payload is only meaningful while push is high
  always_ff @(posedge clk) begin
    if (accept) begin
      cmdOut.cmd.op     <= reqOp;
      cmdOut.cmd.part   <= reqPart;
      cmdOut.cmd.addr   <= reqAddr;
      cmdOut.cmd.wdata  <= reqWdata;
      cmdOut.cmd.preErr <= preErr;
    end
  end

endmodule

// File: src/fuseCmdQueue.sv
// Fuse command queue
// FIFO between the issue stage and the access engine, forwarding one
// command at a time against the engine's single credit
`include "fuse_params.svh"

module fuseCmdQueue
  import fusePkg::*;
(
  input  logic    clk,
  input  logic    rstN,
  fuseCmdIntf.dst inQ,
  fuseCmdIntf.src outQ
);

  localparam int Depth  = `FUSE_QUEUE_DEPTH;
  localparam int PtrW   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountW = $clog2(Depth + 1);

  fuseCmdT           mem [Depth];
  logic [PtrW-1:0]   wrPtr;
  logic [PtrW-1:0]   rdPtr;
  logic [CountW-1:0] count;
  logic              engCredit;
  logic              headValid;
  logic              send;
  fuseCmdT           head;

  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    nextPtr = (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // An arriving command bypasses storage when the FIFO is empty
  assign headValid = (count != '0) || inQ.push;
  assign head      = (count == '0) ? inQ.cmd : mem[rdPtr];
  assign send      = headValid && engCredit;

  // Each command sent on frees one entry upstream
  assign inQ.creditReturn = send;

  // The bypass still writes and reads the same slot, so pointers stay aligned
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      count     <= '0;
      engCredit <= 1'b1;
      outQ.push <= 1'b0;
    end else begin
      if (inQ.push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (send) begin
        rdPtr <= nextPtr(rdPtr);
      end
      count <= count + CountW'(inQ.push) - CountW'(send);
      // Engine holds at most one command so its credit is a single bit
      engCredit <= (engCredit && !send) || outQ.creditReturn;
      outQ.push <= send;
    end
  end

  // Storage and the outgoing command carry no reset
  always_ff @(posedge clk) begin
    if (inQ.push) begin
      mem[wrPtr] <= inQ.cmd;
    end
    if (send) begin
      outQ.cmd <= head;
    end
  end

endmodule

// File: src/fuseDai.sv
// Fuse direct-access engine
// Executes one read or program at a time against the fuse array and
// falls into a terminal error state once escalation is seen
`include "fuse_params.svh"

module fuseDai
  import fusePkg::*;
(
  input  logic                    clk,
  input  logic                    rstN,
  fuseCmdIntf.dst                 cmdIn,
  input  logic                    escalated,
  output logic                    rspValid,
  output fuseErrE                 rspErr,
  output logic [`FUSE_WORD_W-1:0] rspData,
  output logic                    fsmError
);

  localparam int Words = `FUSE_NUM_PART * `FUSE_PART_WORDS;
  localparam int IdxW  = $clog2(Words);

  logic [`FUSE_WORD_W-1:0] fuseArray [Words];
  daiStateE                state;
  fuseCmdT                 cmdQ;
  logic [IdxW-1:0]         idx;
  logic [`FUSE_WORD_W-1:0] curWord;
  fuseErrE                 accessErr;
  logic [`FUSE_WORD_W-1:0] accessData;
  logic                    progOk;
  logic                    rspFire;
  fuseErrE                 rspErrNext;
  logic [`FUSE_WORD_W-1:0] rspDataNext;

  // Partition selects the upper index bits, word address the lower
  assign idx     = {cmdQ.part, cmdQ.addr};
  assign curWord = fuseArray[idx];

  // Outcome of the command held in AccessSt
  // A word that is no longer zero has been programmed and cannot be again
  always_comb begin
    if (escalated) begin
      accessErr = FsmStateError;
    end else if (cmdQ.preErr != NoErr) begin
      accessErr = cmdQ.preErr;
    end else if (cmdQ.op == OpProgram && curWord != '0) begin
      accessErr = BlankErr;
    end else begin
      accessErr = NoErr;
    end
  end

  // Only a clean read returns data
  assign accessData = (accessErr == NoErr && cmdQ.op == OpRead) ? curWord : '0;
  assign progOk     = (state == AccessSt) && (accessErr == NoErr) && (cmdQ.op == OpProgram);

  // Normal responses come out of AccessSt
  // Once escalated, every popped command is answered straight away with an error
  assign rspFire     = (state == AccessSt) ||
                       (cmdIn.push && (state == ErrorSt || (state == IdleSt && escalated)));
  assign rspErrNext  = (state == AccessSt) ? accessErr : FsmStateError;
  assign rspDataNext = (state == AccessSt) ? accessData : '0;

  assign fsmError = state == ErrorSt;

  // Engine is free again once it answers, which hands the credit back
  assign cmdIn.creditReturn = rspValid;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state    <= IdleSt;
      rspValid <= 1'b0;
    end else begin
      rspValid <= rspFire;
      case (state)
        IdleSt: begin
          if (escalated) begin
            state <= ErrorSt;
          end else if (cmdIn.push) begin
            state <= AccessSt;
          end
        end
        AccessSt: state <= RespSt;
        RespSt:   state <= escalated ? ErrorSt : IdleSt;
        // Terminal until reset
        default:  state <= ErrorSt;
      endcase
    end
  end

  // Command and response payload registers
  always_ff @(posedge clk) begin
    if (state == IdleSt && cmdIn.push) begin
      cmdQ <= cmdIn.cmd;
    end
    if (rspFire) begin
      rspErr  <= rspErrNext;
      rspData <= rspDataNext;
    end
  end

  // Fuse array starts blank and each word takes one program only
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < Words; i++) begin
        fuseArray[i] <= '0;
      end
    end else if (progOk) begin
      fuseArray[idx] <= cmdQ.wdata;
    end
  end

endmodule

// File: src/fuseCtrlTop.sv
// Fuse controller top level
// Connects life-cycle locking, command issue, the command queue and the
// access engine to plain host request and response ports
`include "fuse_params.svh"

module fuseCtrlTop
  import fusePkg::*;
(
  input  logic                                clk,
  input  logic                                rstN,
  input  lcStateE                             lcState,
  input  logic                                escalateEn,
  input  logic                                reqValid,
  output logic                                reqReady,
  input  fuseOpE                              reqOp,
  input  logic [$clog2(`FUSE_NUM_PART)-1:0]   reqPart,
  input  logic [$clog2(`FUSE_PART_WORDS)-1:0] reqAddr,
  input  logic [`FUSE_WORD_W-1:0]             reqWdata,
  output logic                                rspValid,
  output fuseErrE                             rspErr,
  output logic [`FUSE_WORD_W-1:0]             rspData,
  output logic                                fsmError
);

  logic [`FUSE_NUM_PART-1:0] writeLock;
  logic                      escalated;

  // Issue to queue, then queue to engine
  fuseCmdIntf issueQ ();
  fuseCmdIntf queueDai ();

  lcPartitionLock lcLock (
    .clk        (clk),
    .rstN       (rstN),
    .lcState    (lcState),
    .escalateEn (escalateEn),
    .writeLock  (writeLock),
    .escalated  (escalated)
  );

  fuseCmdIssue cmdIssue (
    .clk       (clk),
    .rstN      (rstN),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .reqOp     (reqOp),
    .reqPart   (reqPart),
    .reqAddr   (reqAddr),
    .reqWdata  (reqWdata),
    .writeLock (writeLock),
    .escalated (escalated),
    .cmdOut    (issueQ.src)
  );

  fuseCmdQueue cmdQueue (
    .clk  (clk),
    .rstN (rstN),
    .inQ  (issueQ.dst),
    .outQ (queueDai.src)
  );

  fuseDai dai (
    .clk       (clk),
    .rstN      (rstN),
    .cmdIn     (queueDai.dst),
    .escalated (escalated),
    .rspValid  (rspValid),
    .rspErr    (rspErr),
    .rspData   (rspData),
    .fsmError  (fsmError)
  );

endmodule

// File: testbench/fuseCtrlTb.sv
// Fuse controller testbench
// Walks a table of host commands through life-cycle steps, a burst and escalation
// and checks every in-order response against the table
`include "fuse_params.svh"

module fuseCtrlTb
  import fusePkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct {
    lcStateE                             lc;
    logic                                esc;
    fuseOpE                              op;
    logic [$clog2(`FUSE_NUM_PART)-1:0]   part;
    logic [$clog2(`FUSE_PART_WORDS)-1:0] addr;
    logic [`FUSE_WORD_W-1:0]             wdata;
    fuseErrE                             expErr;
    logic [`FUSE_WORD_W-1:0]             expData;
  } stepT;

  localparam int NumSteps      = 26;
  localparam int TimeoutCycles = NumSteps * (`FUSE_QUEUE_DEPTH + 4) + 50;

  logic clk, rstN, escalateEn, reqValid, reqReady, rspValid, fsmError;
  lcStateE lcState;
  fuseOpE reqOp;
  fuseErrE rspErr;
  logic [$clog2(`FUSE_NUM_PART)-1:0] reqPart;
  logic [$clog2(`FUSE_PART_WORDS)-1:0] reqAddr;
  logic [`FUSE_WORD_W-1:0] reqWdata, rspData;
  stepT tbl [NumSteps];
  int nSteps = 0, mismatches = 0, failures = 0, cycleCount = 0;
  int escCycles;
  int expQ [$];
  logic [`FUSE_WORD_W-1:0] rngState = 32'h03838e57;
  logic [`FUSE_WORD_W-1:0] d [14];
  logic escStart;

  fuseCtrlTop dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic addStep(input lcStateE lc, input logic esc, input fuseOpE op,
                         input logic [$clog2(`FUSE_NUM_PART)-1:0] part,
                         input logic [$clog2(`FUSE_PART_WORDS)-1:0] addr,
                         input logic [`FUSE_WORD_W-1:0] wd, input fuseErrE e,
                         input logic [`FUSE_WORD_W-1:0] dat);
    tbl[nSteps] = '{lc, esc, op, part, addr, wd, e, dat};
    nSteps++;
  endtask

  task automatic checkErr(input string name, input fuseErrE got, input fuseErrE exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic checkData(input string name, input logic [`FUSE_WORD_W-1:0] got,
                           input logic [`FUSE_WORD_W-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Responses are a one-cycle pulse, taken at the falling edge and matched in order
  always @(negedge clk) begin
    if (rstN && rspValid) begin
      if (expQ.size() == 0) begin
        failures++;
        $display("t=%0t response arrived with no request outstanding", $time);
      end else begin
        checkErr("rspErr", rspErr, tbl[expQ[0]].expErr);
        checkData("rspData", rspData, tbl[expQ[0]].expData);
        void'(expQ.pop_front());
      end
    end
  end

  initial begin
    rstN = 1'b0;
    lcState = Raw;
    escalateEn = 1'b0;
    reqValid = 1'b0;
    reqOp = OpRead;
    reqPart = '0;
    reqAddr = '0;
    reqWdata = '0;
    foreach (d[k]) begin
      rngState = xorshift32(rngState);
      d[k] = rngState;
    end
    // Raw locks nothing, so program once, read back and try to program again
    addStep(Raw, 0, OpProgram, 0, 1, d[0], NoErr, 0);
    addStep(Raw, 0, OpRead, 0, 1, 0, NoErr, d[0]);
    addStep(Raw, 0, OpProgram, 0, 1, d[1], BlankErr, 0);
    addStep(Raw, 0, OpRead, 0, 1, 0, NoErr, d[0]);
    addStep(Raw, 0, OpProgram, 1, 2, d[2], NoErr, 0);
    addStep(Raw, 0, OpProgram, 2, 3, d[3], NoErr, 0);
    // Dev has passed the phase of partition 0 only
    addStep(Dev, 0, OpProgram, 0, 4, d[4], AccessErr, 0);
    addStep(Dev, 0, OpRead, 0, 1, 0, NoErr, d[0]);
    addStep(Dev, 0, OpProgram, 1, 4, d[5], NoErr, 0);
    addStep(Dev, 0, OpProgram, 3, 0, d[6], NoErr, 0);
    // Prod locks partitions 0 and 1 and these ten go back to back as a burst
    addStep(Prod, 0, OpProgram, 1, 5, d[7], AccessErr, 0);
    // The refused program must have left its word blank
    addStep(Prod, 0, OpRead, 1, 5, 0, NoErr, 0);
    addStep(Prod, 0, OpRead, 1, 4, 0, NoErr, d[5]);
    addStep(Prod, 0, OpProgram, 2, 5, d[8], NoErr, 0);
    addStep(Prod, 0, OpRead, 2, 5, 0, NoErr, d[8]);
    addStep(Prod, 0, OpRead, 2, 3, 0, NoErr, d[3]);
    addStep(Prod, 0, OpProgram, 3, 1, d[9], NoErr, 0);
    addStep(Prod, 0, OpRead, 3, 1, 0, NoErr, d[9]);
    addStep(Prod, 0, OpProgram, 3, 1, d[10], BlankErr, 0);
    addStep(Prod, 0, OpRead, 1, 2, 0, NoErr, d[2]);
    // Unknown code decodes to Scrap and locks every partition but the last
    addStep(lcStateE'(8'h00), 0, OpProgram, 2, 6, d[11], AccessErr, 0);
    addStep(lcStateE'(8'h00), 0, OpRead, 2, 5, 0, NoErr, d[8]);
    addStep(lcStateE'(8'h00), 0, OpProgram, 3, 2, d[12], NoErr, 0);
    // After escalation nothing gets through
    addStep(Prod, 1, OpRead, 0, 1, 0, FsmStateError, 0);
    addStep(Prod, 1, OpProgram, 3, 3, d[13], FsmStateError, 0);
    addStep(Prod, 1, OpRead, 3, 2, 0, FsmStateError, 0);
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    if (!reqReady || rspValid || fsmError) begin
      failures++;
      $display("t=%0t outputs not at their idle values after reset", $time);
    end
    @(posedge clk);
    for (int i = 0; i < NumSteps; i++) begin
      // A new life-cycle or escalation setting waits for the pipeline to drain
      if (tbl[i].lc !== lcState || tbl[i].esc !== escalateEn) begin
        escStart = tbl[i].esc && !escalateEn;
        reqValid <= 1'b0;
        while (expQ.size() != 0) @(posedge clk);
        lcState <= tbl[i].lc;
        escalateEn <= tbl[i].esc;
        // fsmError is looked at mid-cycle, counting cycles from the edge that raised escalateEn
        if (escStart) begin
          escCycles = 0;
          do begin
            @(negedge clk);
            escCycles++;
          end while (!fsmError && escCycles < `FUSE_ESC_LATENCY);
          if (!fsmError) begin
            failures++;
            $display("t=%0t fsmError still low %0d cycles after escalation", $time,
                     `FUSE_ESC_LATENCY);
          end
        end
        repeat (2) @(posedge clk);
      end
      reqValid <= 1'b1;
      reqOp <= tbl[i].op;
      reqPart <= tbl[i].part;
      reqAddr <= tbl[i].addr;
      reqWdata <= tbl[i].wdata;
      do @(negedge clk); while (!reqReady);
      @(posedge clk);
      expQ.push_back(i);
    end
    reqValid <= 1'b0;
    while (expQ.size() != 0) @(posedge clk);
    // Leave room for a stray extra response to show up
    repeat (8) @(posedge clk);
    @(negedge clk);
    // The error state is terminal until reset
    if (escalateEn && !fsmError) begin
      failures++;
      $display("t=%0t fsmError dropped after escalation", $time);
    end
    $display("Errors: %0d value mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    wait (cycleCount >= TimeoutCycles);
    $display("Timeout after %0d cycles, %0d responses never arrived", cycleCount, expQ.size());
    $display("Errors: %0d value mismatches, %0d other failures", mismatches, failures + 1);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: build.f
+incdir+src
src/fusePkg.sv
src/fuseCmdIntf.sv
src/lcPartitionLock.sv
src/fuseCmdIssue.sv
src/fuseCmdQueue.sv
src/fuseDai.sv
src/fuseCtrlTop.sv
testbench/fuseCtrlTb.sv

// File: Bender.yml
package:
  name: fuse_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/fusePkg.sv
      - src/fuseCmdIntf.sv
      - src/lcPartitionLock.sv
      - src/fuseCmdIssue.sv
      - src/fuseCmdQueue.sv
      - src/fuseDai.sv
      - src/fuseCtrlTop.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/fuseCtrlTb.sv
